// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tb_mips_core
FILELIST = project.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): $(FILELIST) *.sv *.svh
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// File: control_decoder.sv
// Instruction decoder
// Opcode and function code to control word, unknown encodings to a bubble

`timescale 1ns/1ns

module control_decoder (
    input  mips_pkg::instr_t instr_i,
    output mips_pkg::ctrl_t  ctrl_o
);
    import mips_pkg::*;

    always_comb begin
        ctrl_o = '0;
        case (instr_i.opcode)
            OP_SPECIAL: begin
                ctrl_o.gpr_we   = 1'b1;
                ctrl_o.wa_is_rd = 1'b1;
                case (instr_i.funct)
                    F_ADDU:  ctrl_o.alu_op = ALU_ADD;
                    F_SUBU:  ctrl_o.alu_op = ALU_SUB;
                    F_AND:   ctrl_o.alu_op = ALU_AND;
                    F_OR:    ctrl_o.alu_op = ALU_OR;
                    F_XOR:   ctrl_o.alu_op = ALU_XOR;
                    F_SLT:   ctrl_o.alu_op = ALU_SLT;
                    default: ctrl_o = '0;           // Shifts, jumps and the rest
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.gpr_we  = 1'b1;
            end
            OP_ORI: begin
                ctrl_o.alu_op       = ALU_OR;
                ctrl_o.use_imm      = 1'b1;
                ctrl_o.imm_zero_ext = 1'b1;
                ctrl_o.gpr_we       = 1'b1;
            end
            // Address is rs plus offset
            OP_LW: begin
                ctrl_o.use_imm  = 1'b1;
                ctrl_o.gpr_we   = 1'b1;
                ctrl_o.mem_read = 1'b1;
            end
            OP_SW: begin
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.mem_write = 1'b1;
            end
            OP_BEQ:  ctrl_o.branch = 1'b1;
            OP_BNE: begin
                ctrl_o.branch    = 1'b1;
                ctrl_o.branch_ne = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: decode_stage.sv
// Decode stage
// Register read, decode-side forwarding, branch compare and target
// ID/EX register with bubble insertion on stall

`timescale 1ns/1ns
`include "mips_settings.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::instr_t    instr_i,
    input  mips_pkg::word_t     pc4_i,
    input  logic                stall_i,
    input  mips_pkg::fwd_sel_e  fwd_rs_i,
    input  mips_pkg::fwd_sel_e  fwd_rt_i,
    pipe_status_if.decode       status,
    output mips_pkg::reg_addr_t rs_o,
    output mips_pkg::reg_addr_t rt_o,
    output logic                branch_o,
    output logic                branch_taken_o,
    output mips_pkg::word_t     branch_target_o,
    output mips_pkg::ctrl_t     ex_ctrl_o,
    output mips_pkg::word_t     ex_rs_val_o,
    output mips_pkg::word_t     ex_rt_val_o,
    output mips_pkg::reg_addr_t ex_rs_o,
    output mips_pkg::reg_addr_t ex_rt_o,
    output mips_pkg::reg_addr_t ex_rd_o,
    output logic [15:0]         ex_imm_o
);
    import mips_pkg::*;

    ctrl_t       ctrl;
    word_t       gpr_rs;
    word_t       gpr_rt;
    word_t       rs_val;
    word_t       rt_val;
    logic [15:0] imm;

    assign rs_o = instr_i.rs;
    assign rt_o = instr_i.rt;
    assign imm  = instr_i[15:0];

    control_decoder i_control_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    // Written from write-back
    gpr_file i_gpr_file (
        .clk    (clk),
        .ra_a_i (instr_i.rs),
        .ra_b_i (instr_i.rt),
        .rd_a_o (gpr_rs),
        .rd_b_o (gpr_rt),
        .wa_i   (status.wb_wa),
        .we_i   (status.wb_we),
        .wd_i   (status.wb_data)
    );

    assign rs_val = fwd_select(fwd_rs_i, gpr_rs, status.mem_result, status.wb_data);
    assign rt_val = fwd_select(fwd_rt_i, gpr_rt, status.mem_result, status.wb_data);

    // --------------------------------------------------
    // Branch resolution
    // --------------------------------------------------
    assign branch_o        = ctrl.branch;
    assign branch_taken_o  = ctrl.branch && ((rs_val == rt_val) != ctrl.branch_ne);
    assign branch_target_o = pc4_i + {{(`MIPS_XLEN-18){imm[15]}}, imm, 2'b00};

    // --------------------------------------------------
    // ID/EX register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        ex_rs_val_o <= rs_val;
        ex_rt_val_o <= rt_val;
        ex_rd_o     <= instr_i.rd;
        ex_imm_o    <= imm;
        if (rst || stall_i) begin
            ex_ctrl_o <= '0;        // Bubble, no register sources
            ex_rs_o   <= '0;
            ex_rt_o   <= '0;
        end else begin
            ex_ctrl_o <= ctrl;
            ex_rs_o   <= instr_i.rs;
            ex_rt_o   <= instr_i.rt;
        end
    end

endmodule

// File: execute_stage.sv
// Execute stage
// Operand forwarding, immediate extension, ALU, destination select
// EX/MEM register

`timescale 1ns/1ns
`include "mips_settings.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::ctrl_t     ctrl_i,
    input  mips_pkg::word_t     rs_val_i,
    input  mips_pkg::word_t     rt_val_i,
    input  mips_pkg::reg_addr_t rs_i,
    input  mips_pkg::reg_addr_t rt_i,
    input  mips_pkg::reg_addr_t rd_i,
    input  logic [15:0]         imm_i,
    input  mips_pkg::fwd_sel_e  fwd_rs_i,
    input  mips_pkg::fwd_sel_e  fwd_rt_i,
    pipe_status_if.execute      status,
    output mips_pkg::ctrl_t     mem_ctrl_o,
    output mips_pkg::word_t     mem_result_o,
    output mips_pkg::word_t     mem_store_o
);
    import mips_pkg::*;

    word_t op_a;
    word_t rt_fwd;       // Also the store data
    word_t op_b;
    word_t imm_ext;
    word_t alu_out;

    assign op_a   = fwd_select(fwd_rs_i, rs_val_i, status.mem_result, status.wb_data);
    assign rt_fwd = fwd_select(fwd_rt_i, rt_val_i, status.mem_result, status.wb_data);

    assign imm_ext = ctrl_i.imm_zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm_i}
                                         : {{(`MIPS_XLEN-16){imm_i[15]}}, imm_i};
    assign op_b    = ctrl_i.use_imm ? imm_ext : rt_fwd;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = word_t'($signed(op_a) < $signed(op_b));
            default: alu_out = op_a + op_b;         // ADD, addresses too
        endcase
    end

    // Seen by hazard logic this cycle
    assign status.ex_wa       = ctrl_i.wa_is_rd ? rd_i : rt_i;
    assign status.ex_we       = ctrl_i.gpr_we;
    assign status.ex_mem_read = ctrl_i.mem_read;

    always_ff @(posedge clk) begin
        mem_result_o <= alu_out;
        mem_store_o  <= rt_fwd;
        if (rst) begin
            mem_ctrl_o <= '0;
        end else begin
            mem_ctrl_o <= ctrl_i;
        end
    end

    // Register 0 is never forwarded and always reads zero in decode
    a_rs_zero: assert property (@(posedge clk) disable iff (rst)
        (ctrl_i != '0 && rs_i == '0) |-> (op_a == '0))
        else $error("execute: rs is register 0 but operand A is %h", op_a);

endmodule

// File: fetch_stage.sv
// Fetch stage
// PC register, next-PC selection and the IF/ID register

`timescale 1ns/1ns
`include "mips_settings.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall_i,
    input  logic             branch_taken_i,
    input  mips_pkg::word_t  branch_target_i,
    output mips_pkg::word_t  iport_addr_o,
    input  mips_pkg::word_t  iport_data_i,
    output mips_pkg::instr_t id_instr_o,
    output mips_pkg::word_t  id_pc4_o
);
    import mips_pkg::*;

    word_t pc;
    word_t pc4;
    word_t pc_next;

    assign pc4          = pc + word_t'(4);
    // Branch in decode, so the slot instruction is fetched already
    assign pc_next      = branch_taken_i ? branch_target_i : pc4;
    assign iport_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `MIPS_RESET_PC;
            id_instr_o <= '0;               // Decodes as a bubble
        end else if (!stall_i) begin
            pc         <= pc_next;
            id_instr_o <= iport_data_i;
            id_pc4_o   <= pc4;
        end
    end

    // Targets come from decode as PC+4 plus a shifted offset
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("fetch: PC %h not word aligned", pc);

endmodule

// File: gpr_file.sv
// General purpose register file
// 32 entries, two read ports with write bypass, one write port

`timescale 1ns/1ns
`include "mips_settings.svh"

module gpr_file (
    input  logic                clk,
    input  mips_pkg::reg_addr_t ra_a_i,
    input  mips_pkg::reg_addr_t ra_b_i,
    output mips_pkg::word_t     rd_a_o,
    output mips_pkg::word_t     rd_b_o,
    input  mips_pkg::reg_addr_t wa_i,
    input  logic                we_i,
    input  mips_pkg::word_t     wd_i
);
    import mips_pkg::*;

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // Write in the same cycle returns the new value
    assign rd_a_o = (ra_a_i == '0) ? '0 : (we_i && wa_i == ra_a_i) ? wd_i : regs[ra_a_i];
    assign rd_b_o = (ra_b_i == '0) ? '0 : (we_i && wa_i == ra_b_i) ? wd_i : regs[ra_b_i];

endmodule

// File: hazard_unit.sv
// Hazard unit
// Forward selects for decode and execute, decode stall

`timescale 1ns/1ns

module hazard_unit (
    pipe_status_if.hazard       status,
    input  mips_pkg::reg_addr_t id_rs_i,
    input  mips_pkg::reg_addr_t id_rt_i,
    input  logic                id_branch_i,
    input  mips_pkg::reg_addr_t ex_rs_i,
    input  mips_pkg::reg_addr_t ex_rt_i,
    output mips_pkg::fwd_sel_e  fwd_id_rs_o,
    output mips_pkg::fwd_sel_e  fwd_id_rt_o,
    output mips_pkg::fwd_sel_e  fwd_ex_rs_o,
    output mips_pkg::fwd_sel_e  fwd_ex_rt_o,
    output logic                stall_o
);
    import mips_pkg::*;

    logic mem_id_en;
    logic load_use;
    logic branch_ex;
    logic branch_ld;

    // Memory stage wins over write-back, register 0 never forwards
    function automatic fwd_sel_e pick(reg_addr_t src, logic mem_en);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (src != '0 && status.wb_we && status.wb_wa == src) sel = FWD_WB;
        if (src != '0 && mem_en && status.mem_wa == src) sel = FWD_MEM;
        return sel;
    endfunction

    // Decode reads rs or rt from this destination
    function automatic logic id_reads(reg_addr_t wa);
        return wa != '0 && (wa == id_rs_i || wa == id_rt_i);
    endfunction

    // Load data is not back in time for decode
    assign mem_id_en = status.mem_we && !status.mem_mem_read;

    assign fwd_id_rs_o = pick(id_rs_i, mem_id_en);
    assign fwd_id_rt_o = pick(id_rt_i, mem_id_en);
    assign fwd_ex_rs_o = pick(ex_rs_i, status.mem_we);
    assign fwd_ex_rt_o = pick(ex_rt_i, status.mem_we);

    // --------------------------------------------------
    // Decode stall
    // --------------------------------------------------
    assign load_use  = status.ex_mem_read && id_reads(status.ex_wa);
    assign branch_ex = id_branch_i && status.ex_we && id_reads(status.ex_wa);
    assign branch_ld = id_branch_i && status.mem_mem_read && id_reads(status.mem_wa);
    assign stall_o   = load_use || branch_ex || branch_ld;

    // Load-use stall keeps a consumer out of execute while its load is in memory
    a_no_load_fwd: assert property (@(posedge status.clk)
        status.mem_mem_read |-> (fwd_ex_rs_o != FWD_MEM && fwd_ex_rt_o != FWD_MEM))
        else $error("hazard: memory-stage forward selected for a load");

endmodule

// File: memory_stage.sv
// Memory stage
// Data port drive, MEM/WB register and the write-back value

`timescale 1ns/1ns

module memory_stage (
    input  logic            clk,
    input  logic            rst,
    input  mips_pkg::ctrl_t ctrl_i,
    input  mips_pkg::word_t result_i,
    input  mips_pkg::word_t store_i,
    output mips_pkg::word_t dport_addr_o,
    output mips_pkg::word_t dport_wdata_o,
    output logic            dport_we_o,
    output logic            dport_re_o,
    input  mips_pkg::word_t dport_rdata_i,
    pipe_status_if.memory   status
);
    import mips_pkg::*;

    reg_addr_t mem_wa;      // Destination, moves with EX/MEM
    reg_addr_t wb_wa;
    logic      wb_we;
    word_t     wb_data;

    assign dport_addr_o  = result_i;
    assign dport_wdata_o = store_i;
    assign dport_we_o    = ctrl_i.mem_write;
    assign dport_re_o    = ctrl_i.mem_read;

    assign status.mem_wa       = mem_wa;
    assign status.mem_we       = ctrl_i.gpr_we;
    assign status.mem_mem_read = ctrl_i.mem_read;
    assign status.mem_result   = result_i;

    always_ff @(posedge clk) begin
        mem_wa  <= status.ex_wa;
        wb_wa   <= mem_wa;
        wb_data <= ctrl_i.mem_read ? dport_rdata_i : result_i;
        wb_we   <= rst ? 1'b0 : ctrl_i.gpr_we;
    end

    assign status.wb_wa   = wb_wa;
    assign status.wb_we   = wb_we;
    assign status.wb_data = wb_data;

endmodule

// File: mips_core.sv
// Top level of the five-stage MIPS32 subset core
// Fetch, decode, execute, memory and hazard instances with their wiring

`timescale 1ns/1ns

module mips_core (
    input  logic            clk,
    input  logic            rst,
    output mips_pkg::word_t iport_addr_o,
    input  mips_pkg::word_t iport_data_i,
    output mips_pkg::word_t dport_addr_o,
    output mips_pkg::word_t dport_wdata_o,
    output logic            dport_we_o,
    output logic            dport_re_o,
    input  mips_pkg::word_t dport_rdata_i
);
    import mips_pkg::*;

    instr_t    id_instr;
    word_t     id_pc4;
    logic      stall;
    logic      branch_taken;
    word_t     branch_target;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    logic      id_branch;
    fwd_sel_e  fwd_id_rs;
    fwd_sel_e  fwd_id_rt;
    fwd_sel_e  fwd_ex_rs;
    fwd_sel_e  fwd_ex_rt;
    ctrl_t     ex_ctrl;
    word_t     ex_rs_val;
    word_t     ex_rt_val;
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    reg_addr_t ex_rd;
    logic [15:0] ex_imm;
    ctrl_t     mem_ctrl;
    word_t     mem_result;
    word_t     mem_store;

    pipe_status_if status (.clk(clk));

    fetch_stage i_fetch_stage (
        .clk             (clk),
        .rst             (rst),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .iport_addr_o    (iport_addr_o),
        .iport_data_i    (iport_data_i),
        .id_instr_o      (id_instr),
        .id_pc4_o        (id_pc4)
    );

    decode_stage i_decode_stage (
        .clk             (clk),
        .rst             (rst),
        .instr_i         (id_instr),
        .pc4_i           (id_pc4),
        .stall_i         (stall),
        .fwd_rs_i        (fwd_id_rs),
        .fwd_rt_i        (fwd_id_rt),
        .status          (status),
        .rs_o            (id_rs),
        .rt_o            (id_rt),
        .branch_o        (id_branch),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_ctrl_o       (ex_ctrl),
        .ex_rs_val_o     (ex_rs_val),
        .ex_rt_val_o     (ex_rt_val),
        .ex_rs_o         (ex_rs),
        .ex_rt_o         (ex_rt),
        .ex_rd_o         (ex_rd),
        .ex_imm_o        (ex_imm)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .rst          (rst),
        .ctrl_i       (ex_ctrl),
        .rs_val_i     (ex_rs_val),
        .rt_val_i     (ex_rt_val),
        .rs_i         (ex_rs),
        .rt_i         (ex_rt),
        .rd_i         (ex_rd),
        .imm_i        (ex_imm),
        .fwd_rs_i     (fwd_ex_rs),
        .fwd_rt_i     (fwd_ex_rt),
        .status       (status),
        .mem_ctrl_o   (mem_ctrl),
        .mem_result_o (mem_result),
        .mem_store_o  (mem_store)
    );

    memory_stage i_memory_stage (
        .clk           (clk),
        .rst           (rst),
        .ctrl_i        (mem_ctrl),
        .result_i      (mem_result),
        .store_i       (mem_store),
        .dport_addr_o  (dport_addr_o),
        .dport_wdata_o (dport_wdata_o),
        .dport_we_o    (dport_we_o),
        .dport_re_o    (dport_re_o),
        .dport_rdata_i (dport_rdata_i),
        .status        (status)
    );

    hazard_unit i_hazard_unit (
        .status      (status),
        .id_rs_i     (id_rs),
        .id_rt_i     (id_rt),
        .id_branch_i (id_branch),
        .ex_rs_i     (ex_rs),
        .ex_rt_i     (ex_rt),
        .fwd_id_rs_o (fwd_id_rs),
        .fwd_id_rt_o (fwd_id_rt),
        .fwd_ex_rs_o (fwd_ex_rs),
        .fwd_ex_rt_o (fwd_ex_rt),
        .stall_o     (stall)
    );

endmodule

// File: mips_pkg.sv
// Shared types of the MIPS32 subset core
// Words, register numbers, opcodes, instruction fields, control word
// Forward selects and the forward operand mux

`include "mips_settings.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]       word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    // Immediate is the low 16 bits (rd, shamt, funct)
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;       // Operand B from immediate
        logic    imm_zero_ext;
        logic    gpr_we;
        logic    wa_is_rd;      // Else rt is the destination
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
    } ctrl_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // Operand source for decode and execute alike
    function automatic word_t fwd_select(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                         word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

// File: mips_settings.svh
// Core-wide widths and reset values
// Data width, register address width, register count, first fetch address

`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and address width
`define MIPS_XLEN        32
`define MIPS_REG_ADDR_W  5
`define MIPS_NUM_REGS    32

`define MIPS_RESET_PC    32'h0000_0000   // First fetch after reset

`endif

// File: pipe_status_if.sv
// Write-back targets and results of execute, memory and write-back
// Modports for each producer and for the readers in decode and hazard logic

`timescale 1ns/1ns

interface pipe_status_if (
    input logic clk
);
    import mips_pkg::*;

    reg_addr_t ex_wa;           // Destination of the instruction in execute
    logic      ex_we;
    logic      ex_mem_read;
    reg_addr_t mem_wa;
    logic      mem_we;
    logic      mem_mem_read;
    word_t     mem_result;      // ALU result only, never load data
    reg_addr_t wb_wa;
    logic      wb_we;
    word_t     wb_data;

    modport execute (
        output ex_wa, ex_we, ex_mem_read,
        input  mem_result, wb_data
    );

    modport memory (
        input  ex_wa,
        output mem_wa, mem_we, mem_mem_read, mem_result,
        output wb_wa, wb_we, wb_data
    );

    modport decode (
        input ex_wa, ex_we, ex_mem_read,
        input mem_wa, mem_we, mem_mem_read, mem_result,
        input wb_wa, wb_we, wb_data
    );

    modport hazard (
        input clk,
        input ex_wa, ex_we, ex_mem_read,
        input mem_wa, mem_we, mem_mem_read,
        input wb_wa, wb_we
    );

endinterface

// File: project.f
+incdir+.
mips_pkg.sv
pipe_status_if.sv
fetch_stage.sv
control_decoder.sv
gpr_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
mips_core.sv
tb_mips_core.sv

// File: tb_mips_core.sv
// Testbench for the five-stage MIPS32 subset core
// Instruction and data memory models, program builder, reference interpreter
// Store comparator and the directed and random tests

`timescale 1ns/1ns
`include "mips_settings.svh"

module tb_mips_core;

    logic        clk;
    logic        rst;
    logic [31:0] iport_addr;
    logic [31:0] iport_data;
    logic [31:0] dport_addr;
    logic [31:0] dport_wdata;
    logic        dport_we;
    logic        dport_re;
    logic [31:0] dport_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] prog [256];
    int          prog_len;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] obs_addr [$];
    int          errors;
    int          tests_failed;
    int          tests_run;

    mips_core i_mips_core (
        .clk           (clk),
        .rst           (rst),
        .iport_addr_o  (iport_addr),
        .iport_data_i  (iport_data),
        .dport_addr_o  (dport_addr),
        .dport_wdata_o (dport_wdata),
        .dport_we_o    (dport_we),
        .dport_re_o    (dport_re),
        .dport_rdata_i (dport_rdata)
    );

    // Both memories answer in the same cycle
    assign iport_data  = imem[iport_addr[9:2]];
    assign dport_rdata = dport_re ? dmem[dport_addr[11:2]] : '0;   // Only on a load strobe

    always @(posedge clk) begin
        if (dport_we) dmem[dport_addr[11:2]] <= dport_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Program builder
    // --------------------------------------------------
    function automatic logic [31:0] enc_r(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void emit(logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    function automatic void emit_halt();
        emit(enc_i(6'h04, 5'd0, 5'd0, 16'hffff));  // Branch to itself
        emit(32'h0);
    endfunction

    // Depends on every address bit
    function automatic logic [31:0] fill_word(int idx);
        return {idx[15:0] ^ 16'hc3a5, ~idx[15:0]};
    endfunction

    // --------------------------------------------------
    // Reference interpreter, architectural with delay slots
    // --------------------------------------------------
    function automatic void run_reference();
        logic [31:0] gpr [32];
        logic [31:0] mem [1024];
        logic [31:0] pc, npc, nnpc, ins, a, b, res, imm_s, ea;
        logic [15:0] imm;
        logic [5:0]  op;
        logic [4:0]  rs, rt, rd, wa;
        logic        wr, taken, done;
        int          steps;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) gpr[i] = '0;
        for (int i = 0; i < 1024; i++) mem[i] = fill_word(i);
        pc = `MIPS_RESET_PC;
        npc = pc + 4;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 4000) begin
            ins   = imem[pc[9:2]];
            op    = ins[31:26];
            rs    = ins[25:21];
            rt    = ins[20:16];
            rd    = ins[15:11];
            imm   = ins[15:0];
            a     = gpr[rs];
            b     = gpr[rt];
            imm_s = {{16{imm[15]}}, imm};
            ea    = a + imm_s;
            nnpc  = npc + 4;
            wr    = 1'b1;
            wa    = rt;
            res   = '0;
            case (op)
                6'h00: begin
                    wa = rd;
                    case (ins[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = ea;
                6'h0d: res = a | {16'h0, imm};
                6'h23: res = mem[ea[11:2]];
                6'h2b: begin
                    wr = 1'b0;
                    mem[ea[11:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                6'h04, 6'h05: begin
                    wr    = 1'b0;
                    taken = (a == b) ^ (op == 6'h05);
                    if (taken) nnpc = npc + {imm_s[29:0], 2'b00};
                    if (taken && nnpc == pc) done = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && wa != 5'd0) gpr[wa] = res;
            pc = npc;
            npc = nnpc;
            steps++;
        end
    endfunction

    // Comparator, samples at the falling edge where the port is stable
    always @(negedge clk) begin
        if (!rst && dport_we) begin
            if (obs_addr.size() < exp_addr.size()) begin
                assert (dport_addr == exp_addr[obs_addr.size()]) else begin
                    $display("[FAIL] %0t dport_addr_o got %h expected %h", $time,
                             dport_addr, exp_addr[obs_addr.size()]);
                    errors++;
                end
                assert (dport_wdata == exp_data[obs_addr.size()]) else begin
                    $display("[FAIL] %0t dport_wdata_o got %h expected %h", $time,
                             dport_wdata, exp_data[obs_addr.size()]);
                    errors++;
                end
            end else begin
                assert (1'b0) else begin
                    $display("Store to %h at %0t was not expected", dport_addr, $time);
                    errors++;
                end
            end
            obs_addr.push_back(dport_addr);
        end
    end

    // Loads the program under reset, then checks the idle ports
    task automatic restart_core();
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 256; i++) imem[i] = (i < prog_len) ? prog[i] : 32'h0;
        for (int i = 0; i < 1024; i++) dmem[i] = fill_word(i);
        obs_addr.delete();
        run_reference();
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            if (i == 2) rst = 1'b0;
            @(negedge clk);
            assert (!dport_we && !dport_re) else begin
                $display("[FAIL] %0t dport_we_o/dport_re_o got %b%b expected 00", $time,
                         dport_we, dport_re);
                errors++;
            end
            assert (iport_addr == `MIPS_RESET_PC) else begin
                $display("[FAIL] %0t iport_addr_o got %h expected %h", $time, iport_addr,
                         `MIPS_RESET_PC);
                errors++;
            end
        end
    endtask

    task automatic run_test(string name);
        int cyc;
        int err_before;
        err_before = errors;
        restart_core();
        cyc = 0;
        while (obs_addr.size() < exp_addr.size() && cyc < 3000) begin
            @(posedge clk);
            cyc++;
        end
        if (obs_addr.size() < exp_addr.size()) begin
            $display("Timeout in %s: %0d of %0d stores seen", name, obs_addr.size(),
                     exp_addr.size());
            errors++;
        end
        cyc = 0;
        while (cyc < 20) begin      // Catch stray stores after the last one
            @(posedge clk);
            cyc++;
        end
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("test %s: %0d stores, %0d errors", name, exp_addr.size(), errors - err_before);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    initial begin
        logic [31:0] rnd;
        logic [5:0]  fns [6];
        void'($urandom(32'ha741d797));
        fns = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};
        rst = 1'b1;
        errors = 0;
        tests_failed = 0;
        tests_run = 0;
        for (int i = 0; i < 256; i++) imem[i] = 32'h0;
        for (int i = 0; i < 1024; i++) dmem[i] = fill_word(i);

        prog_len = 0;               // Every R-type and immediate operation
        emit(enc_i(6'h09, 5'd1, 5'd0, 16'h1234));
        emit(enc_i(6'h09, 5'd2, 5'd0, 16'hfffb));
        emit(enc_i(6'h0d, 5'd3, 5'd0, 16'h8001));
        for (int k = 0; k < 6; k++) emit(enc_r(fns[k], 5'(4 + k), 5'd1, 5'd2));
        emit(enc_r(6'h2a, 5'd10, 5'd2, 5'd1));
        emit(enc_r(6'h24, 5'd11, 5'd1, 5'd3));
        for (int k = 1; k < 12; k++) emit(enc_i(6'h2b, 5'(k), 5'd0, 16'(32'h100 + 4 * k)));
        emit_halt();
        run_test("alu");

        prog_len = 0;               // Dependent chain
        emit(enc_i(6'h09, 5'd1, 5'd0, 16'd5));
        emit(enc_r(6'h21, 5'd2, 5'd1, 5'd1));
        emit(enc_r(6'h21, 5'd3, 5'd2, 5'd1));
        emit(enc_r(6'h23, 5'd4, 5'd3, 5'd2));
        emit(enc_i(6'h2b, 5'd4, 5'd0, 16'h0200));
        emit(enc_i(6'h0d, 5'd5, 5'd4, 16'h00f0));
        emit(enc_i(6'h2b, 5'd5, 5'd0, 16'h0204));
        emit(enc_i(6'h2b, 5'd3, 5'd0, 16'h0208));
        emit_halt();
        run_test("forward");

        prog_len = 0;               // Load-use and store of loaded data
        emit(enc_i(6'h23, 5'd1, 5'd0, 16'h0040));
        emit(enc_r(6'h21, 5'd2, 5'd1, 5'd1));
        emit(enc_i(6'h23, 5'd3, 5'd0, 16'h0044));
        emit(enc_i(6'h2b, 5'd3, 5'd0, 16'h0200));
        emit(enc_i(6'h09, 5'd6, 5'd0, 16'h0040));
        emit(enc_i(6'h23, 5'd4, 5'd6, 16'h0008));
        emit(enc_i(6'h09, 5'd5, 5'd4, 16'd1));
        emit(enc_i(6'h2b, 5'd2, 5'd0, 16'h0204));
        emit(enc_i(6'h2b, 5'd5, 5'd0, 16'h0208));
        emit_halt();
        run_test("load");

        prog_len = 0;               // Branches with delay slots
        emit(enc_i(6'h09, 5'd1, 5'd0, 16'd3));
        emit(enc_i(6'h09, 5'd2, 5'd0, 16'd3));
        emit(enc_i(6'h04, 5'd2, 5'd1, 16'd2));     // Taken, skips one
        emit(enc_i(6'h09, 5'd3, 5'd0, 16'd7));
        emit(enc_i(6'h09, 5'd3, 5'd0, 16'd99));
        emit(enc_i(6'h2b, 5'd3, 5'd0, 16'h0300));
        emit(enc_i(6'h05, 5'd2, 5'd1, 16'd2));     // Not taken
        emit(enc_i(6'h09, 5'd5, 5'd0, 16'd11));
        emit(enc_i(6'h09, 5'd5, 5'd5, 16'd1));
        emit(enc_i(6'h2b, 5'd5, 5'd0, 16'h0304));
        emit(enc_i(6'h09, 5'd4, 5'd1, 16'hfffd));
        emit(enc_i(6'h05, 5'd0, 5'd4, 16'd2));     // Depends on r4, not taken
        emit(32'h0);
        emit(enc_i(6'h09, 5'd6, 5'd0, 16'd21));
        emit(enc_i(6'h09, 5'd7, 5'd0, 16'd1));
        emit(enc_i(6'h05, 5'd0, 5'd7, 16'd2));     // Depends on r7, taken
        emit(enc_i(6'h0d, 5'd6, 5'd6, 16'h0100));
        emit(enc_i(6'h09, 5'd6, 5'd0, 16'd0));
        emit(enc_i(6'h2b, 5'd6, 5'd0, 16'h0308));
        emit(enc_i(6'h09, 5'd8, 5'd0, 16'd0));     // Old r8 differs from the load
        emit(enc_i(6'h23, 5'd8, 5'd0, 16'h0040));
        emit(enc_i(6'h05, 5'd0, 5'd8, 16'd2));     // Operand from a load, taken
        emit(enc_i(6'h09, 5'd9, 5'd0, 16'd5));
        emit(enc_i(6'h09, 5'd9, 5'd0, 16'd99));    // Skipped
        emit(enc_i(6'h2b, 5'd9, 5'd0, 16'h030c));
        emit(enc_i(6'h04, 5'd0, 5'd1, 16'd2));     // Not taken beq
        emit(enc_i(6'h2b, 5'd8, 5'd0, 16'h0310));
        emit(enc_i(6'h2b, 5'd1, 5'd0, 16'h0314));
        emit_halt();
        run_test("branch");

        prog_len = 0;               // Random ALU program
        for (int k = 1; k < 32; k++) begin
            rnd = $urandom;
            emit(enc_i(6'h09, 5'(k), 5'd0, rnd[15:0]));
        end
        for (int k = 0; k < 40; k++) begin
            rnd = $urandom;
            case (rnd[31:30])
                2'd0:    emit(enc_i(6'h09, rnd[4:0], rnd[9:5], rnd[25:10]));
                2'd1:    emit(enc_i(6'h0d, rnd[4:0], rnd[9:5], rnd[25:10]));
                default: emit(enc_r(fns[rnd[29:27] % 6], rnd[4:0], rnd[9:5], rnd[14:10]));
            endcase
        end
        for (int k = 1; k < 32; k++) emit(enc_i(6'h2b, 5'(k), 5'd0, 16'(32'h400 + 4 * k)));
        emit_halt();
        run_test("random");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
